//--- hw/conv_buf_pkg.sv
`default_nettype none

package conv_buf_pkg;

    //////////////////////////////////////////////////
    // Datapath and dimension widths
    //////////////////////////////////////////////////

    // Input words, sequence words and pixels
    localparam int DATA_W = 16;
    // Row and column counts and coordinates
    localparam int DIM_W = 8;
    localparam int MAX_COLS = 64;

    // Pixel buffer, three rows of the widest map
    localparam int ROW_BUF_DEPTH = 256;
    localparam int ROW_BUF_AW = 8;
    // Rows held before the first drain
    localparam int PRIME_ROWS = 3;

    // Sequencer memory
    localparam int SEQ_DEPTH = 32;
    localparam int SEQ_AW = 5;

    // Address stage plus output stage in both memories
    localparam int RD_LATENCY = 2;

    // Controller states, binary encoded
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOAD_SEQ,
        ST_PRIME,
        ST_LOAD_ROW,
        ST_ACTIVE
    } buf_state_t;

    // Configuration register select
    typedef enum logic [1:0] {
        CFG_NUM_ROWS = 2'd0,
        CFG_NUM_COLS = 2'd1,
        CFG_SEQ_LEN  = 2'd2
    } cfg_addr_t;

endpackage

`default_nettype wire

//--- hw/delay_line.sv
`default_nettype none

module delay_line #(
    parameter int STAGES = 2,
    parameter int WIDTH  = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // Stage 0 takes the input, last stage drives the output
    logic [WIDTH-1:0] stage_q [STAGES];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            // Shift toward the output
            for (int i = 1; i < STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign dout = stage_q[STAGES-1];

endmodule

`default_nettype wire

//--- hw/seq_ram.sv
`default_nettype none

module seq_ram (
    input  logic                            clk,
    input  logic                            wr_en,
    input  logic [conv_buf_pkg::SEQ_AW-1:0] wr_addr,
    input  logic [conv_buf_pkg::DATA_W-1:0] wr_data,
    input  logic                            rd_en,
    input  logic [conv_buf_pkg::SEQ_AW-1:0] rd_addr,
    output logic [conv_buf_pkg::DATA_W-1:0] rd_data
);
    import conv_buf_pkg::*;

    logic [DATA_W-1:0] mem [SEQ_DEPTH];
    // Address stage of the read pipe
    logic [SEQ_AW-1:0] rd_addr_q;

    // Write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Two cycle read, address then data
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_addr_q <= rd_addr;
        end
        rd_data <= mem[rd_addr_q];
    end

endmodule

`default_nettype wire

//--- hw/row_buf.sv
`default_nettype none

module row_buf (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              wr_en,
    input  logic [conv_buf_pkg::DATA_W-1:0]   wr_data,
    input  logic                              rd_en,
    output logic [conv_buf_pkg::DATA_W-1:0]   rd_data,
    output logic [conv_buf_pkg::ROW_BUF_AW:0] count
);
    import conv_buf_pkg::*;

    logic [DATA_W-1:0]     mem [ROW_BUF_DEPTH];
    // Pointers wrap naturally at the power-of-two depth
    logic [ROW_BUF_AW-1:0] wr_ptr;
    logic [ROW_BUF_AW-1:0] rd_ptr;
    // Address stage of the read pipe
    logic [ROW_BUF_AW-1:0] rd_addr_q;

    //////////////////////////////////////////////////
    // Pointers and occupancy
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Simultaneous write and read leaves count alone
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: begin
                end
            endcase
        end
    end

    // Pixel store
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Read pointer captured, then the word two cycles after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_addr_q <= rd_ptr;
        end
        rd_data <= mem[rd_addr_q];
    end

endmodule

`default_nettype wire

//--- hw/conv_buf_cfg.sv
`default_nettype none

module conv_buf_cfg (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_wr,
    input  conv_buf_pkg::cfg_addr_t         cfg_addr,
    input  logic [conv_buf_pkg::DATA_W-1:0] cfg_wdata,
    input  logic                            busy,
    output logic [conv_buf_pkg::DIM_W-1:0]  num_rows,
    output logic [conv_buf_pkg::DIM_W-1:0]  num_cols,
    output logic [conv_buf_pkg::SEQ_AW:0]   seq_len
);
    import conv_buf_pkg::*;

    // Strobe only takes effect between maps
    logic cfg_we;

    assign cfg_we = cfg_wr && !busy;

    //////////////////////////////////////////////////
    // Map dimension registers
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            num_rows <= '0;
            num_cols <= '0;
            seq_len  <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                CFG_NUM_ROWS: begin
                    num_rows <= cfg_wdata[DIM_W-1:0];
                end
                CFG_NUM_COLS: begin
                    num_cols <= cfg_wdata[DIM_W-1:0];
                end
                CFG_SEQ_LEN: begin
                    // One extra bit so a full SEQ_DEPTH fits
                    seq_len <= cfg_wdata[SEQ_AW:0];
                end
                default: begin
                    // Unmapped select, write dropped
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/conv_buf_ctrl.sv
`default_nettype none

module conv_buf_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              new_map,
    input  logic                              data_valid,
    input  logic                              data_tag,
    input  logic [conv_buf_pkg::DIM_W-1:0]    num_rows,
    input  logic [conv_buf_pkg::DIM_W-1:0]    num_cols,
    input  logic [conv_buf_pkg::SEQ_AW:0]     seq_len,
    input  logic [conv_buf_pkg::ROW_BUF_AW:0] pix_count,
    output logic                              seq_rdy,
    output logic                              pix_rdy,
    output logic                              busy,
    output logic                              map_done,
    output logic                              seq_wr_en,
    output logic [conv_buf_pkg::SEQ_AW-1:0]   seq_wr_addr,
    output logic                              seq_rd_en,
    output logic [conv_buf_pkg::SEQ_AW-1:0]   seq_rd_addr,
    output logic                              pix_wr_en,
    output logic                              pix_rd_en,
    output logic                              out_valid,
    output logic [conv_buf_pkg::DIM_W-1:0]    out_row,
    output logic [conv_buf_pkg::DIM_W-1:0]    out_col,
    output logic [1:0]                        gray_code
);
    import conv_buf_pkg::*;

    buf_state_t         state;
    // Words accepted in the current load phase
    logic [DIM_W+1:0]   load_cnt;
    logic [DIM_W+1:0]   load_cnt_nxt;
    logic [DIM_W+1:0]   load_target;
    logic [DIM_W+1:0]   cols_ext;
    logic               load_done;
    logic               word_fire;
    // Rows written into the buffer so far
    logic [DIM_W-1:0]   rows_in;
    // Coordinates of the next read
    logic [DIM_W-1:0]   row;
    logic [DIM_W-1:0]   col;
    logic               col_last;
    logic               row_last;
    // Cyclic sequence index
    logic [SEQ_AW-1:0]  seq_idx;
    logic [SEQ_AW:0]    seq_idx_nxt;
    logic               seq_wrap;
    logic               rd_fire;
    logic               buf_full;
    logic [1:0]         gray_issue;

    //////////////////////////////////////////////////
    // Input side handshake
    //////////////////////////////////////////////////

    // Count MSB set only at ROW_BUF_DEPTH
    assign buf_full = pix_count[ROW_BUF_AW];

    assign seq_rdy = (state == ST_LOAD_SEQ);
    assign pix_rdy = (state == ST_PRIME || state == ST_LOAD_ROW) && !buf_full;

    // Write strobes line up with data_in of the same cycle
    assign seq_wr_en = seq_rdy && data_valid && !data_tag;
    assign pix_wr_en = pix_rdy && data_valid && data_tag;
    assign word_fire = seq_wr_en || pix_wr_en;

    assign seq_wr_addr = load_cnt[SEQ_AW-1:0];

    // Phase length in words
    assign cols_ext = {2'b00, num_cols};

    always_comb begin
        case (state)
            ST_LOAD_SEQ: load_target = (DIM_W+2)'(seq_len);
            // Three rows, cols times two plus cols
            ST_PRIME:    load_target = cols_ext + {cols_ext[DIM_W:0], 1'b0};
            default:     load_target = cols_ext;
        endcase
    end

    assign load_cnt_nxt = load_cnt + 1'b1;
    assign load_done    = (load_cnt_nxt == load_target);

    //////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////

    // Never read an empty buffer
    assign rd_fire   = (state == ST_ACTIVE) && (pix_count != '0);
    assign pix_rd_en = rd_fire;
    assign seq_rd_en = rd_fire;
    assign seq_rd_addr = seq_idx;

    assign col_last = (col == num_cols - 1'b1);
    assign row_last = (row == num_rows - 1'b1);

    assign seq_idx_nxt = {1'b0, seq_idx} + 1'b1;
    assign seq_wrap    = (seq_idx_nxt == seq_len);

    assign gray_issue = {row[1], row[1] ^ row[0]};

    //////////////////////////////////////////////////
    // State machine and counters
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            busy     <= 1'b0;
            load_cnt <= '0;
            rows_in  <= '0;
            row      <= '0;
            col      <= '0;
            seq_idx  <= '0;
        end else begin
            // Held through the last beat of the pipe
            if (map_done) begin
                busy <= 1'b0;
            end
            if (word_fire) begin
                load_cnt <= load_done ? '0 : load_cnt_nxt;
            end
            case (state)
                ST_IDLE: begin
                    if (new_map && !busy) begin
                        state    <= ST_LOAD_SEQ;
                        busy     <= 1'b1;
                        load_cnt <= '0;
                        rows_in  <= '0;
                        row      <= '0;
                        col      <= '0;
                        seq_idx  <= '0;
                    end
                end
                ST_LOAD_SEQ: begin
                    if (seq_wr_en && load_done) begin
                        state <= ST_PRIME;
                    end
                end
                ST_PRIME: begin
                    if (pix_wr_en && load_done) begin
                        state   <= ST_ACTIVE;
                        rows_in <= DIM_W'(PRIME_ROWS);
                    end
                end
                ST_LOAD_ROW: begin
                    if (pix_wr_en && load_done) begin
                        state   <= ST_ACTIVE;
                        rows_in <= rows_in + 1'b1;
                    end
                end
                ST_ACTIVE: begin
                    if (rd_fire) begin
                        seq_idx <= seq_wrap ? '0 : seq_idx_nxt[SEQ_AW-1:0];
                        if (col_last) begin
                            col <= '0;
                            row <= row + 1'b1;
                            // Refill after each row while input rows remain
                            if (row_last) begin
                                state <= ST_IDLE;
                            end else if (rows_in < num_rows) begin
                                state <= ST_LOAD_ROW;
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Alignment with memory read data
    //////////////////////////////////////////////////
    delay_line #(
        .STAGES (RD_LATENCY),
        .WIDTH  (1)
    ) u_valid_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (rd_fire),
        .dout (out_valid)
    );

    delay_line #(
        .STAGES (RD_LATENCY),
        .WIDTH  (2*DIM_W+2)
    ) u_coord_dly (
        .clk  (clk),
        .rst  (rst),
        .din  ({row, col, gray_issue}),
        .dout ({out_row, out_col, gray_code})
    );

    // Last beat recognised from delayed coordinates
    assign map_done = out_valid && (out_row == num_rows - 1'b1) &&
                      (out_col == num_cols - 1'b1);

endmodule

`default_nettype wire

//--- hw/conv_buf_top.sv
`default_nettype none

module conv_buf_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cfg_wr,
    input  conv_buf_pkg::cfg_addr_t         cfg_addr,
    input  logic [conv_buf_pkg::DATA_W-1:0] cfg_wdata,
    input  logic                            new_map,
    input  logic                            data_valid,
    input  logic                            data_tag,
    input  logic [conv_buf_pkg::DATA_W-1:0] data_in,
    output logic                            seq_rdy,
    output logic                            pix_rdy,
    output logic                            busy,
    output logic                            map_done,
    output logic                            out_valid,
    output logic [conv_buf_pkg::DATA_W-1:0] out_pixel,
    output logic [conv_buf_pkg::DATA_W-1:0] out_seq,
    output logic [conv_buf_pkg::DIM_W-1:0]  out_row,
    output logic [conv_buf_pkg::DIM_W-1:0]  out_col,
    output logic [1:0]                      gray_code
);
    import conv_buf_pkg::*;

    // Map dimensions
    logic [DIM_W-1:0]    num_rows;
    logic [DIM_W-1:0]    num_cols;
    logic [SEQ_AW:0]     seq_len;
    // Sequencer memory strobes
    logic                seq_wr_en;
    logic [SEQ_AW-1:0]   seq_wr_addr;
    logic                seq_rd_en;
    logic [SEQ_AW-1:0]   seq_rd_addr;
    // Pixel buffer strobes
    logic                pix_wr_en;
    logic                pix_rd_en;
    logic [ROW_BUF_AW:0] pix_count;

    conv_buf_cfg u_cfg (
        .clk       (clk),
        .rst       (rst),
        .cfg_wr    (cfg_wr),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .busy      (busy),
        .num_rows  (num_rows),
        .num_cols  (num_cols),
        .seq_len   (seq_len)
    );

    conv_buf_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .new_map     (new_map),
        .data_valid  (data_valid),
        .data_tag    (data_tag),
        .num_rows    (num_rows),
        .num_cols    (num_cols),
        .seq_len     (seq_len),
        .pix_count   (pix_count),
        .seq_rdy     (seq_rdy),
        .pix_rdy     (pix_rdy),
        .busy        (busy),
        .map_done    (map_done),
        .seq_wr_en   (seq_wr_en),
        .seq_wr_addr (seq_wr_addr),
        .seq_rd_en   (seq_rd_en),
        .seq_rd_addr (seq_rd_addr),
        .pix_wr_en   (pix_wr_en),
        .pix_rd_en   (pix_rd_en),
        .out_valid   (out_valid),
        .out_row     (out_row),
        .out_col     (out_col),
        .gray_code   (gray_code)
    );

    // Both memories share the input word bus
    seq_ram u_seq_ram (
        .clk     (clk),
        .wr_en   (seq_wr_en),
        .wr_addr (seq_wr_addr),
        .wr_data (data_in),
        .rd_en   (seq_rd_en),
        .rd_addr (seq_rd_addr),
        .rd_data (out_seq)
    );

    row_buf u_row_buf (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (pix_wr_en),
        .wr_data (data_in),
        .rd_en   (pix_rd_en),
        .rd_data (out_pixel),
        .count   (pix_count)
    );

endmodule

`default_nettype wire

//--- verification/conv_buf_tb.sv
`default_nettype none

module conv_buf_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import conv_buf_pkg::*;

    localparam int          NUM_CASES     = 6;
    localparam int          READY_TIMEOUT = 2000;
    localparam int          DONE_TIMEOUT  = 20000;
    localparam int          MAX_GAP       = 4;
    localparam int unsigned RAND_SEED     = 32'h17a9_d790;

    // One map per table entry
    typedef struct {
        int    rows;
        int    cols;
        int    seq_len;
        int    gap_pct;
        string name;
        int    total;
    } map_case_t;

    logic              clk;
    logic              rst;
    logic              cfg_wr;
    cfg_addr_t         cfg_addr;
    logic [DATA_W-1:0] cfg_wdata;
    logic              new_map;
    logic              data_valid;
    logic              data_tag;
    logic [DATA_W-1:0] data_in;
    logic              seq_rdy;
    logic              pix_rdy;
    logic              busy;
    logic              map_done;
    logic              out_valid;
    logic [DATA_W-1:0] out_pixel;
    logic [DATA_W-1:0] out_seq;
    logic [DIM_W-1:0]  out_row;
    logic [DIM_W-1:0]  out_col;
    logic [1:0]        gray_code;

    map_case_t         cases [NUM_CASES];
    // Reference data of the running map
    logic [DATA_W-1:0] seq_mem [SEQ_DEPTH];
    logic [DATA_W-1:0] pix_q [$];
    string             cur_name;
    int                cur_cols;
    int                cur_seq_len;
    int                cur_total;
    int                beat_cnt;
    int                done_cnt;

    conv_buf_top DUT (
        .clk        (clk),
        .rst        (rst),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .new_map    (new_map),
        .data_valid (data_valid),
        .data_tag   (data_tag),
        .data_in    (data_in),
        .seq_rdy    (seq_rdy),
        .pix_rdy    (pix_rdy),
        .busy       (busy),
        .map_done   (map_done),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_seq    (out_seq),
        .out_row    (out_row),
        .out_col    (out_col),
        .gray_code  (gray_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Failure reporting and checking
    //////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s %s: expected %0h, actual %0h", cur_name, what, expected, actual);
            abort_run("Output mismatch against the reference model");
        end
    endtask

    // Binary to Gray, two bits
    function automatic logic [1:0] gray_of(input logic [1:0] b);
        return b ^ (b >> 1);
    endfunction

    task automatic fill_case_table();
        // rows, cols, seq_len, gap percent, name, expected beats
        cases[0] = '{3, 3, 5, 0, "square_min_rows", 9};
        cases[1] = '{6, 6, 7, 25, "square_gaps", 36};
        cases[2] = '{4, 64, 32, 10, "wide_full_seq", 256};
        cases[3] = '{12, 1, 1, 30, "tall_single_col", 12};
        cases[4] = '{9, 2, 4, 40, "tall_narrow", 18};
        cases[5] = '{5, 13, 3, 50, "odd_heavy_gaps", 65};
    endtask

    //////////////////////////////////////////////////
    // Stimulus tasks
    //////////////////////////////////////////////////
    task automatic write_cfg(input cfg_addr_t addr, input int value);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= DATA_W'(value);
        @(posedge clk);
        cfg_wr    <= 1'b0;
    endtask

    task automatic start_map();
        int waited;
        // Nothing may be ready before the map starts
        @(negedge clk);
        check_equal("seq_rdy before new_map", 32'd0, 32'(seq_rdy));
        check_equal("pix_rdy before new_map", 32'd0, 32'(pix_rdy));
        @(posedge clk);
        new_map <= 1'b1;
        @(posedge clk);
        new_map <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk);
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("Timeout: busy never rose after new_map");
            end
        end while (!busy);
    endtask

    // Gap cycles may offer a stray word with the other tag
    // Real word then held until its ready is seen
    task automatic send_word(input logic tag, input logic [DATA_W-1:0] word,
                             input int gap_pct);
        int gaps;
        int waited;
        logic taken;
        gaps = 0;
        while (gaps < MAX_GAP && int'($urandom_range(99)) < gap_pct) begin
            @(posedge clk);
            data_valid <= 1'($urandom);
            data_tag   <= ~tag;
            data_in    <= DATA_W'($urandom);
            gaps++;
        end
        @(posedge clk);
        data_valid <= 1'b1;
        data_tag   <= tag;
        data_in    <= word;
        waited = 0;
        // Transfer happens on the edge after ready is seen here
        do begin
            @(negedge clk);
            taken = tag ? pix_rdy : seq_rdy;
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("Timeout: input word was never accepted");
            end
        end while (!taken);
    endtask

    task automatic wait_map_end();
        int waited;
        waited = 0;
        while (done_cnt == 0) begin
            @(negedge clk);
            waited++;
            if (waited > DONE_TIMEOUT) begin
                abort_run("Timeout: map_done never pulsed");
            end
        end
        waited = 0;
        while (busy) begin
            @(negedge clk);
            waited++;
            if (waited > READY_TIMEOUT) begin
                abort_run("Timeout: busy stayed high after map_done");
            end
        end
    endtask

    task automatic run_case(input int idx);
        int n_pix;
        cur_name    = cases[idx].name;
        cur_cols    = cases[idx].cols;
        cur_seq_len = cases[idx].seq_len;
        cur_total   = cases[idx].total;
        n_pix       = cases[idx].rows * cases[idx].cols;
        for (int k = 0; k < SEQ_DEPTH; k++) begin
            seq_mem[k] = DATA_W'($urandom);
        end
        pix_q.delete();
        for (int k = 0; k < n_pix; k++) begin
            pix_q.push_back(DATA_W'($urandom));
        end
        beat_cnt = 0;
        done_cnt = 0;
        write_cfg(CFG_NUM_ROWS, cases[idx].rows);
        write_cfg(CFG_NUM_COLS, cases[idx].cols);
        write_cfg(CFG_SEQ_LEN, cases[idx].seq_len);
        start_map();
        // Writes while busy leave this map untouched
        write_cfg(CFG_NUM_ROWS, int'($urandom_range(3, 20)));
        write_cfg(CFG_NUM_COLS, int'($urandom_range(1, MAX_COLS)));
        write_cfg(CFG_SEQ_LEN, int'($urandom_range(1, SEQ_DEPTH)));
        for (int k = 0; k < cur_seq_len; k++) begin
            send_word(1'b0, seq_mem[k], cases[idx].gap_pct);
        end
        for (int k = 0; k < n_pix; k++) begin
            send_word(1'b1, pix_q[k], cases[idx].gap_pct);
        end
        @(posedge clk);
        data_valid <= 1'b0;
        wait_map_end();
    endtask

    //////////////////////////////////////////////////
    // Output monitor against the reference model
    //////////////////////////////////////////////////
    initial begin
        int k;
        int exp_row;
        forever begin
            @(negedge clk);
            if (!rst && out_valid) begin
                k = beat_cnt;
                if (k >= cur_total) begin
                    abort_run("Output beat beyond the expected pixel count");
                end
                exp_row = k / cur_cols;
                check_equal("out_pixel", 32'(pix_q[k]), 32'(out_pixel));
                check_equal("out_seq", 32'(seq_mem[k % cur_seq_len]), 32'(out_seq));
                check_equal("out_row", 32'(exp_row), 32'(out_row));
                check_equal("out_col", 32'(k % cur_cols), 32'(out_col));
                check_equal("gray_code", 32'(gray_of(2'(exp_row))), 32'(gray_code));
                check_equal("map_done", 32'(k == cur_total - 1), 32'(map_done));
                beat_cnt++;
                if (map_done) begin
                    done_cnt++;
                end
            end else if (!rst) begin
                check_equal("map_done without out_valid", 32'd0, 32'(map_done));
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        void'($urandom(RAND_SEED));
        rst        = 1'b1;
        cfg_wr     = 1'b0;
        cfg_addr   = CFG_NUM_ROWS;
        cfg_wdata  = '0;
        new_map    = 1'b0;
        data_valid = 1'b0;
        data_tag   = 1'b0;
        data_in    = '0;
        cur_name   = "reset";
        cur_cols    = 1;
        cur_seq_len = 1;
        cur_total   = 0;
        beat_cnt    = 0;
        done_cnt    = 0;
        fill_case_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // Quiet after reset and with no map requested
        repeat (4) begin
            @(negedge clk);
            check_equal("seq_rdy after reset", 32'd0, 32'(seq_rdy));
            check_equal("pix_rdy after reset", 32'd0, 32'(pix_rdy));
            check_equal("busy after reset", 32'd0, 32'(busy));
            check_equal("out_valid after reset", 32'd0, 32'(out_valid));
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i);
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_buf_top.f
hw/conv_buf_pkg.sv
hw/delay_line.sv
hw/seq_ram.sv
hw/row_buf.sv
hw/conv_buf_cfg.sv
hw/conv_buf_ctrl.sv
hw/conv_buf_top.sv
verification/conv_buf_tb.sv

//--- Makefile
VERILATOR  ?= verilator
FILELIST   := conv_buf_top.f
TB_TOP     := conv_buf_tb
RTL_TOP    := conv_buf_top
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
PASS_TEXT  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
